// ==== verilog/fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////
    // line geometry
    ////////////////////

    localparam int LINE_BYTES     = 16;
    localparam int WORD_BYTES     = 4;
    localparam int WORDS_PER_LINE = LINE_BYTES / WORD_BYTES;
    // byte offset within one line
    localparam int OFS_W          = 4;

    ////////////////////
    // encodings
    ////////////////////

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_FILL,
        // fill still on the bus but made stale by a resteer
        FS_DRAIN
    } fetch_state_e;

    typedef enum logic [2:0] {
        BUF_HOLD,
        BUF_LOAD,
        BUF_SHIFT,
        BUF_SHIFT_LOAD,
        BUF_FLUSH
    } buf_op_e;

endpackage

// ==== verilog/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl
    import fetch_pkg::*;
(
    input  logic             clk,
    input  logic             rst_i,
    input  logic             resteer_i,
    input  logic [31:0]      resteer_addr_i,
    input  logic             stall_i,
    input  logic [4:0]       d_length_i,
    input  logic             cur_valid_i,
    input  logic             next_valid_i,
    input  logic             fill_done_i,
    output logic             fill_start_o,
    output logic [27:0]      fill_addr_o,
    output buf_op_e          buf_op_o,
    output logic [OFS_W-1:0] byte_ofs_o,
    output logic [31:0]      packet_addr_o,
    output logic             packet_valid_o
);

    fetch_state_e   state;
    logic           armed;
    logic           staged;
    logic [27:0]    fetch_line;
    logic [31:0]    pkt_addr;
    logic [OFS_W:0] ofs_sum;
    logic           accept;
    logic           shift;
    logic           fill_kept;

    // packet needs both lines since it may span the boundary
    assign packet_valid_o = cur_valid_i && next_valid_i;
    assign packet_addr_o  = pkt_addr;
    assign byte_ofs_o     = pkt_addr[OFS_W-1:0];
    assign fill_addr_o    = fetch_line;

    // a resteer in the same cycle wins over acceptance
    assign accept    = packet_valid_o && !stall_i && !resteer_i;
    assign ofs_sum   = {1'b0, byte_ofs_o} + d_length_i;
    assign shift     = accept && ofs_sum[OFS_W];
    assign fill_kept = fill_done_i && (state == FS_FILL);

    // a finished line can wait in the fill engine as a third line,
    // so the next fill starts while decode still drains the buffer
    assign fill_start_o = (state == FS_IDLE) && armed && !staged && !resteer_i;

    ////////////////////
    // buffer command
    ////////////////////

    always_comb begin
        buf_op_o = BUF_HOLD;
        if (resteer_i) begin
            buf_op_o = BUF_FLUSH;
        end else if (shift) begin
            buf_op_o = (staged || fill_kept) ? BUF_SHIFT_LOAD : BUF_SHIFT;
        end else if (fill_kept && !next_valid_i) begin
            buf_op_o = BUF_LOAD;
        end
    end

    ////////////////////
    // pointers and fsm
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state      <= FS_IDLE;
            armed      <= 1'b0;
            staged     <= 1'b0;
            fetch_line <= '0;
            pkt_addr   <= '0;
        end else if (resteer_i) begin
            armed      <= 1'b1;
            staged     <= 1'b0;
            fetch_line <= resteer_addr_i[31:OFS_W];
            pkt_addr   <= resteer_addr_i;
            // a fill still on the bus has to run out first
            if (state != FS_IDLE && !fill_done_i) begin
                state <= FS_DRAIN;
            end else begin
                state <= FS_IDLE;
            end
        end else begin
            if (accept) begin
                pkt_addr <= pkt_addr + 32'(d_length_i);
            end
            // staged line leaves on a shift, arrives when both slots are full
            if (shift && staged) begin
                staged <= 1'b0;
            end else if (fill_kept && next_valid_i && !shift) begin
                staged <= 1'b1;
            end
            case (state)
                FS_IDLE: begin
                    if (fill_start_o) begin
                        state      <= FS_FILL;
                        fetch_line <= fetch_line + 28'd1;
                    end
                end
                FS_FILL, FS_DRAIN: begin
                    if (fill_done_i) begin
                        state <= FS_IDLE;
                    end
                end
                default: state <= FS_IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/line_fill.sv ====
`timescale 1ns/1ps

module line_fill
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  logic [27:0]             line_addr_i,
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic [31:0]             wb_adr_o,
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_ack_i,
    output logic                    done_o,
    output logic [LINE_BYTES*8-1:0] line_o
);

    logic                    busy;
    logic [27:0]             line_addr;
    logic [1:0]              word_cnt;
    logic [LINE_BYTES*8-1:0] line_q;
    logic                    last_word;

    // one request per word, cyc held over the whole line
    assign wb_cyc_o  = busy;
    assign wb_stb_o  = busy;
    assign wb_adr_o  = {line_addr, word_cnt, 2'b00};
    assign last_word = (word_cnt == 2'(WORDS_PER_LINE - 1));
    assign done_o    = busy && wb_ack_i && last_word;

    // top word comes straight off the bus in the done cycle
    assign line_o = done_o ?
        {wb_dat_i, line_q[(WORDS_PER_LINE-1)*WORD_BYTES*8-1:0]} : line_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            busy     <= 1'b0;
            word_cnt <= '0;
        end else if (!busy) begin
            if (start_i) begin
                busy     <= 1'b1;
                word_cnt <= '0;
            end
        end else if (wb_ack_i) begin
            word_cnt <= word_cnt + 2'd1;
            if (last_word) begin
                busy <= 1'b0;
            end
        end
    end

    // little endian, word n lands in bytes 4n to 4n+3
    always_ff @(posedge clk) begin
        if (!busy && start_i) begin
            line_addr <= line_addr_i;
        end
        if (busy && wb_ack_i) begin
            line_q[word_cnt*(WORD_BYTES*8) +: WORD_BYTES*8] <= wb_dat_i;
        end
    end

endmodule

// ==== verilog/line_buffer.sv ====
`timescale 1ns/1ps

module line_buffer
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_i,
    input  buf_op_e                 op_i,
    input  logic [LINE_BYTES*8-1:0] line_i,
    output logic [LINE_BYTES*8-1:0] cur_o,
    output logic [LINE_BYTES*8-1:0] next_o,
    output logic                    cur_valid_o,
    output logic                    next_valid_o
);

    ////////////////////
    // valid bits
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cur_valid_o  <= 1'b0;
            next_valid_o <= 1'b0;
        end else begin
            case (op_i)
                BUF_LOAD: begin
                    if (!cur_valid_o) begin
                        cur_valid_o <= 1'b1;
                    end else begin
                        next_valid_o <= 1'b1;
                    end
                end
                BUF_SHIFT: begin
                    cur_valid_o  <= next_valid_o;
                    next_valid_o <= 1'b0;
                end
                BUF_SHIFT_LOAD: begin
                    cur_valid_o  <= next_valid_o;
                    next_valid_o <= 1'b1;
                end
                BUF_FLUSH: begin
                    cur_valid_o  <= 1'b0;
                    next_valid_o <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // line data
    ////////////////////

    always_ff @(posedge clk) begin
        case (op_i)
            // first empty slot takes the line
            BUF_LOAD: begin
                if (!cur_valid_o) begin
                    cur_o <= line_i;
                end else begin
                    next_o <= line_i;
                end
            end
            BUF_SHIFT: cur_o <= next_o;
            BUF_SHIFT_LOAD: begin
                cur_o  <= next_o;
                next_o <= line_i;
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/packet_align.sv ====
`timescale 1ns/1ps

module packet_align
    import fetch_pkg::*;
(
    input  logic [LINE_BYTES*8-1:0] cur_i,
    input  logic [LINE_BYTES*8-1:0] next_i,
    input  logic [OFS_W-1:0]        ofs_i,
    output logic [LINE_BYTES*8-1:0] packet_o
);

    // 32 byte window, rotated in place one stage at a time
    logic [2*LINE_BYTES*8-1:0] win;

    ////////////////////
    // log shifter
    ////////////////////

    always_comb begin
        // next sits above cur so byte order follows the address
        win = {next_i, cur_i};
        // stage s rotates right by 2**s bytes when ofs bit s is set
        for (int s = 0; s < OFS_W; s++) begin
            if (ofs_i[s]) begin
                win = (win >> (8 << s)) | (win << (2 * LINE_BYTES * 8 - (8 << s)));
            end
        end
    end

    // low line of the rotated window starts at the offset byte
    assign packet_o = win[LINE_BYTES*8-1:0];

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_i,

    ////////////////////
    // resteer
    ////////////////////
    input  logic                    resteer_i,
    input  logic [31:0]             resteer_addr_i,

    ////////////////////
    // decode side
    ////////////////////
    input  logic                    stall_i,
    input  logic [4:0]              d_length_i,
    output logic [LINE_BYTES*8-1:0] packet_o,
    output logic [31:0]             packet_addr_o,
    output logic                    packet_valid_o,

    ////////////////////
    // wishbone master
    ////////////////////
    output logic                    wb_cyc_o,
    output logic                    wb_stb_o,
    output logic [31:0]             wb_adr_o,
    input  logic [31:0]             wb_dat_i,
    input  logic                    wb_ack_i
);

    logic                    fill_start;
    logic [27:0]             fill_addr;
    logic                    fill_done;
    logic [LINE_BYTES*8-1:0] fill_line;
    buf_op_e                 buf_op;
    logic                    cur_valid;
    logic                    next_valid;
    logic [LINE_BYTES*8-1:0] cur_line;
    logic [LINE_BYTES*8-1:0] next_line;
    logic [OFS_W-1:0]        byte_ofs;

    fetch_ctrl u_ctrl (
        .clk            (clk),
        .rst_i          (rst_i),
        .resteer_i      (resteer_i),
        .resteer_addr_i (resteer_addr_i),
        .stall_i        (stall_i),
        .d_length_i     (d_length_i),
        .cur_valid_i    (cur_valid),
        .next_valid_i   (next_valid),
        .fill_done_i    (fill_done),
        .fill_start_o   (fill_start),
        .fill_addr_o    (fill_addr),
        .buf_op_o       (buf_op),
        .byte_ofs_o     (byte_ofs),
        .packet_addr_o  (packet_addr_o),
        .packet_valid_o (packet_valid_o)
    );

    line_fill u_fill (
        .clk         (clk),
        .rst_i       (rst_i),
        .start_i     (fill_start),
        .line_addr_i (fill_addr),
        .wb_cyc_o    (wb_cyc_o),
        .wb_stb_o    (wb_stb_o),
        .wb_adr_o    (wb_adr_o),
        .wb_dat_i    (wb_dat_i),
        .wb_ack_i    (wb_ack_i),
        .done_o      (fill_done),
        .line_o      (fill_line)
    );

    line_buffer u_buf (
        .clk          (clk),
        .rst_i        (rst_i),
        .op_i         (buf_op),
        .line_i       (fill_line),
        .cur_o        (cur_line),
        .next_o       (next_line),
        .cur_valid_o  (cur_valid),
        .next_valid_o (next_valid)
    );

    packet_align u_align (
        .cur_i    (cur_line),
        .next_i   (next_line),
        .ofs_i    (byte_ofs),
        .packet_o (packet_o)
    );

endmodule

// ==== tb/fetch_assert.sv ====
`timescale 1ns/1ps

module fetch_assert
    import fetch_pkg::*;
(
    input logic                    clk,
    input logic                    rst_i,
    input logic                    resteer_i,
    input logic                    stall_i,
    input logic [LINE_BYTES*8-1:0] packet_o,
    input logic [31:0]             packet_addr_o,
    input logic                    packet_valid_o,
    input logic                    wb_cyc_o,
    input logic                    wb_stb_o,
    input logic [31:0]             wb_adr_o,
    input logic                    wb_ack_i
);

    int   fail_cnt = 0;
    logic steered;

    // set once the first resteer has been seen
    always_ff @(posedge clk) begin
        if (rst_i) begin
            steered <= 1'b0;
        end else if (resteer_i) begin
            steered <= 1'b1;
        end
    end

    ////////////////////
    // decode side
    ////////////////////

    idle_before_resteer: assert property (@(posedge clk) disable iff (rst_i)
        !steered |-> !wb_cyc_o && !wb_stb_o && !packet_valid_o)
        else begin
            $error("bus or packet active before the first resteer");
            fail_cnt++;
        end

    // stalled packet holds unless a resteer flushes it
    packet_hold: assert property (@(posedge clk) disable iff (rst_i)
        packet_valid_o && stall_i && !resteer_i |=>
        $stable(packet_o) && $stable(packet_addr_o))
        else begin
            $error("packet changed while decode stalled");
            fail_cnt++;
        end

    ////////////////////
    // wishbone
    ////////////////////

    stb_in_cycle: assert property (@(posedge clk) disable iff (rst_i)
        wb_stb_o |-> wb_cyc_o)
        else begin
            $error("wb_stb_o high outside a bus cycle");
            fail_cnt++;
        end

    adr_aligned: assert property (@(posedge clk) disable iff (rst_i)
        wb_stb_o |-> wb_adr_o[1:0] == 2'b00)
        else begin
            $error("wb_adr_o not word aligned");
            fail_cnt++;
        end

    adr_hold: assert property (@(posedge clk) disable iff (rst_i)
        wb_stb_o && !wb_ack_i |=> $stable(wb_adr_o))
        else begin
            $error("wb_adr_o moved before wb_ack_i");
            fail_cnt++;
        end

endmodule

bind fetch_top fetch_assert u_chk (
    .clk            (clk),
    .rst_i          (rst_i),
    .resteer_i      (resteer_i),
    .stall_i        (stall_i),
    .packet_o       (packet_o),
    .packet_addr_o  (packet_addr_o),
    .packet_valid_o (packet_valid_o),
    .wb_cyc_o       (wb_cyc_o),
    .wb_stb_o       (wb_stb_o),
    .wb_adr_o       (wb_adr_o),
    .wb_ack_i       (wb_ack_i)
);

// ==== tb/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb
    import fetch_pkg::*;
();

    localparam int N_ACCEPT    = 600;
    localparam int N_RESTEER   = 8;
    localparam int RESTEER_GAP = N_ACCEPT / N_RESTEER;
    // worst case one slow line fill per packet, plus drain time per resteer
    localparam int MAX_CYCLES  = N_ACCEPT * 32 + N_RESTEER * 100;

    logic                    clk;
    logic                    rst_i;
    logic                    resteer_i;
    logic [31:0]             resteer_addr_i;
    logic                    stall_i;
    logic [4:0]              d_length_i;
    logic [LINE_BYTES*8-1:0] packet_o;
    logic [31:0]             packet_addr_o;
    logic                    packet_valid_o;
    logic                    wb_cyc_o;
    logic                    wb_stb_o;
    logic [31:0]             wb_adr_o;
    logic [31:0]             wb_dat_i;
    logic                    wb_ack_i;

    logic [31:0] seed;
    logic [31:0] exp_addr;
    int          wait_left;
    int          acc_cnt;
    int          resteer_cnt;
    int          cycle_cnt;
    int          addr_err;
    int          byte_err;

    fetch_top u_dut (
        .clk            (clk),
        .rst_i          (rst_i),
        .resteer_i      (resteer_i),
        .resteer_addr_i (resteer_addr_i),
        .stall_i        (stall_i),
        .d_length_i     (d_length_i),
        .packet_o       (packet_o),
        .packet_addr_o  (packet_addr_o),
        .packet_valid_o (packet_valid_o),
        .wb_cyc_o       (wb_cyc_o),
        .wb_stb_o       (wb_stb_o),
        .wb_adr_o       (wb_adr_o),
        .wb_dat_i       (wb_dat_i),
        .wb_ack_i       (wb_ack_i)
    );

    always #20 clk = ~clk;

    ////////////////////
    // models
    ////////////////////

    // lcg step, upper bits only
    function automatic int next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return int'(seed[30:15]);
    endfunction

    function automatic logic [7:0] mem_byte(input logic [31:0] addr);
        return addr[7:0] + addr[15:8];
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {mem_byte(addr + 32'd3), mem_byte(addr + 32'd2),
                mem_byte(addr + 32'd1), mem_byte(addr)};
    endfunction

    // memory answers after 0 to 3 wait states
    task automatic serve_memory();
        if (wb_stb_o && wait_left == 0) begin
            wb_ack_i  = 1'b1;
            wb_dat_i  = mem_word(wb_adr_o);
            wait_left = next_random() % 4;
        end else begin
            wb_ack_i = 1'b0;
            if (wb_stb_o) begin
                wait_left = wait_left - 1;
            end
        end
    endtask

    task automatic check_packet(input logic [31:0] addr, input logic [127:0] pkt);
        logic [127:0] exp_pkt;
        for (int k = 0; k < LINE_BYTES; k++) begin
            exp_pkt[k*8 +: 8] = mem_byte(exp_addr + 32'(k));
        end
        assert (addr == exp_addr) else begin
            addr_err++;
            $display("FAIL %0d ns: packet address %h, expected %h",
                     $time, addr, exp_addr);
        end
        assert (pkt == exp_pkt) else begin
            byte_err++;
            $display("FAIL %0d ns: packet at %h is %h, expected %h",
                     $time, exp_addr, pkt, exp_pkt);
        end
    endtask

    task automatic drive_decode(input logic pv, input logic [31:0] pa,
                                input logic [127:0] pk, input logic cyc);
        logic want_resteer;
        resteer_i  = 1'b0;
        stall_i    = (next_random() % 4) == 0;
        d_length_i = 5'(next_random() % 16 + 1);
        // odd numbered resteers wait for a fill on the bus
        want_resteer = resteer_cnt < N_RESTEER && acc_cnt >= resteer_cnt * RESTEER_GAP
                       && (cyc || resteer_cnt % 2 == 0);
        if (want_resteer) begin
            resteer_i      = 1'b1;
            resteer_addr_i = {16'(next_random()), 16'(next_random())};
            exp_addr       = resteer_addr_i;
            resteer_cnt++;
        end else if (pv && !stall_i) begin
            check_packet(pa, pk);
            exp_addr = exp_addr + 32'(d_length_i);
            acc_cnt++;
        end
    endtask

    task automatic run_cycle();
        logic         pv;
        logic [31:0]  pa;
        logic [127:0] pk;
        logic         cyc;
        @(posedge clk);
        #2;
        pv  = packet_valid_o;
        pa  = packet_addr_o;
        pk  = packet_o;
        cyc = wb_cyc_o;
        serve_memory();
        drive_decode(pv, pa, pk, cyc);
    endtask

    ////////////////////
    // run
    ////////////////////

    initial begin
        clk            = 1'b0;
        rst_i          = 1'b1;
        resteer_i      = 1'b0;
        resteer_addr_i = '0;
        stall_i        = 1'b0;
        d_length_i     = 5'd1;
        wb_dat_i       = '0;
        wb_ack_i       = 1'b0;
        seed           = 32'd4227;
        exp_addr       = '0;
        wait_left      = 0;
        acc_cnt        = 0;
        resteer_cnt    = 0;
        addr_err       = 0;
        byte_err       = 0;
        repeat (16) @(posedge clk);
        #2;
        rst_i = 1'b0;
        while (acc_cnt < N_ACCEPT || resteer_cnt < N_RESTEER) begin
            run_cycle();
        end
        // let the last edge reach the assertions
        @(posedge clk);
        #2;
        $display("errors: address %0d, bytes %0d, assertions %0d (accepted %0d, resteers %0d)",
                 addr_err, byte_err, u_dut.u_chk.fail_cnt, acc_cnt, resteer_cnt);
        if (addr_err + byte_err + u_dut.u_chk.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < MAX_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== build.f ====
verilog/fetch_pkg.sv
verilog/fetch_ctrl.sv
verilog/line_fill.sv
verilog/line_buffer.sv
verilog/packet_align.sv
verilog/fetch_top.sv
tb/fetch_assert.sv
tb/fetch_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the fetch unit testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module fetch_tb \
        -Mdir obj_dir -o fetch_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/fetch_sim +verilator+error+limit+1000); then
    echo "$output"
    echo "simulation exited with an error status"
    exit 1
fi
echo "$output"

if grep -qx "RESULT: PASS" <<< "$output"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1
